// File: common/mem_geom_pkg.sv
package mem_geom_pkg;

  // Default array size in bytes
  parameter int MEM_SIZE = 4096;

  // Byte address bits
  parameter int ADDR_WIDTH = $clog2(MEM_SIZE);

  // One memory line, 16 bytes at the default
  parameter int LINE_WIDTH = 128;

  // Access size of a request, in bytes from the request address
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,  // 1 byte
    SIZE_HALF = 2'd1,  // 2 bytes
    SIZE_WORD = 2'd2,  // 4 bytes
    SIZE_LINE = 2'd3   // Whole line
  } access_size_t;

endpackage

// File: common/mem_req_pkg.sv
package mem_req_pkg;

  // Issue to data_valid, equal to the pipeline depth
  parameter int MEM_LATENCY = 10;

  // Stage where the array is read or written
  parameter int WR_COMMIT_STAGE = 5;

  // Requester of a memory access
  typedef enum logic {
    CLIENT_INSTR = 1'b0,
    CLIENT_DATA  = 1'b1
  } client_t;

endpackage

// File: mem/mem.sv
module mem #(
  parameter int MEM_SIZE   = mem_geom_pkg::MEM_SIZE,
  parameter int LINE_WIDTH = mem_geom_pkg::LINE_WIDTH
)(
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                rd_req_valid_i,
  input  logic                                wr_req_valid_i,
  input  logic                                req_is_instr_i,
  input  logic [mem_geom_pkg::ADDR_WIDTH-1:0] address_i,
  input  logic [LINE_WIDTH-1:0]               wr_data_i,
  input  mem_geom_pkg::access_size_t          access_size_i,
  output logic                                data_valid_o,
  output logic                                data_is_instr_o,
  output logic [LINE_WIDTH-1:0]               data_o
);

  import mem_geom_pkg::*;
  import mem_req_pkg::*;

  localparam int LINE_BYTES = LINE_WIDTH / 8;
  localparam int CS         = WR_COMMIT_STAGE;

  logic [7:0] mem_array [MEM_SIZE];

  // Control stages, reset
  logic valid_q [1:MEM_LATENCY];
  logic instr_q [1:MEM_LATENCY];
  logic wr_q    [1:CS];

  // Request payload up to the commit stage
  access_size_t          size_q  [1:CS];
  logic [ADDR_WIDTH-1:0] addr_q  [1:CS];
  logic [LINE_WIDTH-1:0] wdata_q [1:CS];

  // Read line after the commit stage
  logic [LINE_WIDTH-1:0] rdata_q [CS+1:MEM_LATENCY];

  logic                  commit_wr;
  logic                  commit_rd;
  logic [LINE_BYTES-1:0] byte_en;
  logic [LINE_WIDTH-1:0] rd_line;

  function automatic int size_to_bytes(access_size_t size);
    case (size)
      SIZE_BYTE: return 1;
      SIZE_HALF: return 2;
      SIZE_WORD: return 4;
      default:   return LINE_BYTES;
    endcase
  endfunction

  assign commit_wr = valid_q[CS] && wr_q[CS];
  assign commit_rd = valid_q[CS] && !wr_q[CS];

  always_comb begin
    for (int i = 0; i < LINE_BYTES; i++) begin
      byte_en[i] = (i < size_to_bytes(size_q[CS]));
    end
  end

  // Whole line from the request address, little-endian
  always_comb begin
    rd_line = '0;
    if (commit_rd) begin
      for (int i = 0; i < LINE_BYTES; i++) begin
        rd_line[8*i +: 8] = mem_array[addr_q[CS] + i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int s = 1; s <= MEM_LATENCY; s++) begin
        valid_q[s] <= 1'b0;
        instr_q[s] <= 1'b0;
      end
      for (int s = 1; s <= CS; s++) begin
        wr_q[s] <= 1'b0;
      end
    end else begin
      valid_q[1] <= rd_req_valid_i | wr_req_valid_i;
      instr_q[1] <= req_is_instr_i;
      wr_q[1]    <= wr_req_valid_i;
      for (int s = 2; s <= CS; s++) begin
        valid_q[s] <= valid_q[s-1];
        instr_q[s] <= instr_q[s-1];
        wr_q[s]    <= wr_q[s-1];
      end
      valid_q[CS+1] <= commit_rd;  // Writes end here, no response
      instr_q[CS+1] <= instr_q[CS];
      for (int s = CS + 2; s <= MEM_LATENCY; s++) begin
        valid_q[s] <= valid_q[s-1];
        instr_q[s] <= instr_q[s-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    size_q[1]  <= access_size_i;
    addr_q[1]  <= address_i;
    wdata_q[1] <= wr_data_i;
    for (int s = 2; s <= CS; s++) begin
      size_q[s]  <= size_q[s-1];
      addr_q[s]  <= addr_q[s-1];
      wdata_q[s] <= wdata_q[s-1];
    end
    rdata_q[CS+1] <= rd_line;
    for (int s = CS + 2; s <= MEM_LATENCY; s++) begin
      rdata_q[s] <= rdata_q[s-1];
    end
  end

  // Only the bytes covered by the access size change
  always_ff @(posedge clk_i) begin
    if (commit_wr) begin
      for (int i = 0; i < LINE_BYTES; i++) begin
        if (byte_en[i]) begin
          mem_array[addr_q[CS] + i] <= wdata_q[CS][8*i +: 8];
        end
      end
    end
  end

  assign data_valid_o    = valid_q[MEM_LATENCY];
  assign data_is_instr_o = instr_q[MEM_LATENCY];
  assign data_o          = rdata_q[MEM_LATENCY];

  // Bytes past the end of the image stay zero
  initial begin
    for (int i = 0; i < MEM_SIZE; i++) begin
      mem_array[i] = 8'h00;
    end
    $readmemh("mem/mem_init.mem", mem_array);
  end

endmodule

// File: verilog/mem_arbiter.sv
module mem_arbiter #(
  parameter int MEM_SIZE   = mem_geom_pkg::MEM_SIZE,
  parameter int LINE_WIDTH = mem_geom_pkg::LINE_WIDTH
)(
  input  logic                                clk_i,
  input  logic                                rst_i,
  // Instruction fetch port
  input  logic                                ireq_i,
  input  logic [mem_geom_pkg::ADDR_WIDTH-1:0] iaddr_i,
  output logic                                iack_o,
  output logic [LINE_WIDTH-1:0]               idata_o,
  // Data port
  input  logic                                dreq_i,
  input  logic                                dwe_i,
  input  logic [mem_geom_pkg::ADDR_WIDTH-1:0] daddr_i,
  input  mem_geom_pkg::access_size_t          dsize_i,
  input  logic [LINE_WIDTH-1:0]               dwdata_i,
  output logic                                dack_o,
  output logic [LINE_WIDTH-1:0]               drdata_o,
  // Memory request side
  output logic                                rd_req_valid_o,
  output logic                                wr_req_valid_o,
  output logic                                req_is_instr_o,
  output logic [mem_geom_pkg::ADDR_WIDTH-1:0] address_o,
  output logic [LINE_WIDTH-1:0]               wr_data_o,
  output mem_geom_pkg::access_size_t          access_size_o,
  // Memory response side
  input  logic                                data_valid_i,
  input  logic                                data_is_instr_i,
  input  logic [LINE_WIDTH-1:0]               data_i
);

  import mem_geom_pkg::*;
  import mem_req_pkg::*;

  typedef enum logic [1:0] {
    PORT_IDLE,
    PORT_WAIT,  // Issued, response not yet seen
    PORT_ACK    // Ack held until req falls
  } port_state_t;

  // Keeps the address inside a power-of-two array
  localparam logic [ADDR_WIDTH-1:0] ADDR_MASK = ADDR_WIDTH'(MEM_SIZE - 1);

  port_state_t istate_q, istate_d;
  port_state_t dstate_q, dstate_d;
  logic        i_issue;
  logic        d_issue;
  client_t     grant;
  client_t     resp_client;
  logic        i_resp;
  logic        d_resp;

  assign d_issue = (dstate_q == PORT_IDLE) && dreq_i;
  assign i_issue = (istate_q == PORT_IDLE) && ireq_i && !d_issue;  // Data port wins
  assign grant   = d_issue ? CLIENT_DATA : CLIENT_INSTR;

  assign resp_client = data_is_instr_i ? CLIENT_INSTR : CLIENT_DATA;
  assign i_resp      = data_valid_i && (resp_client == CLIENT_INSTR);
  assign d_resp      = data_valid_i && (resp_client == CLIENT_DATA);

  always_comb begin
    istate_d = istate_q;
    case (istate_q)
      PORT_IDLE: if (i_issue) istate_d = PORT_WAIT;
      PORT_WAIT: if (i_resp) istate_d = PORT_ACK;
      PORT_ACK:  if (!ireq_i) istate_d = PORT_IDLE;
      default:   istate_d = PORT_IDLE;
    endcase
  end

  always_comb begin
    dstate_d = dstate_q;
    case (dstate_q)
      PORT_IDLE: if (d_issue) dstate_d = PORT_WAIT;
      PORT_WAIT: if (dwe_i || d_resp) dstate_d = PORT_ACK;  // Write acks the cycle after issue
      PORT_ACK:  if (!dreq_i) dstate_d = PORT_IDLE;
      default:   dstate_d = PORT_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      istate_q       <= PORT_IDLE;
      dstate_q       <= PORT_IDLE;
      rd_req_valid_o <= 1'b0;
      wr_req_valid_o <= 1'b0;
    end else begin
      istate_q       <= istate_d;
      dstate_q       <= dstate_d;
      rd_req_valid_o <= i_issue | (d_issue & !dwe_i);
      wr_req_valid_o <= d_issue & dwe_i;
    end
  end

  // Request fields, loaded only on an issue
  always_ff @(posedge clk_i) begin
    if (i_issue || d_issue) begin
      req_is_instr_o <= (grant == CLIENT_INSTR);
      address_o      <= (d_issue ? daddr_i : iaddr_i) & ADDR_MASK;
      wr_data_o      <= dwdata_i;
      access_size_o  <= d_issue ? dsize_i : SIZE_LINE;  // Fetches read whole lines
    end
  end

  // Response lines held for the ack phase
  always_ff @(posedge clk_i) begin
    if (i_resp && istate_q == PORT_WAIT) begin
      idata_o <= data_i;
    end
    if (d_resp && dstate_q == PORT_WAIT) begin
      drdata_o <= data_i;
    end
  end

  assign iack_o = (istate_q == PORT_ACK);
  assign dack_o = (dstate_q == PORT_ACK);

endmodule

// File: verilog/mem_subsys_top.sv
module mem_subsys_top #(
  parameter int MEM_SIZE   = mem_geom_pkg::MEM_SIZE,
  parameter int LINE_WIDTH = mem_geom_pkg::LINE_WIDTH
)(
  input  logic                                clk_i,
  input  logic                                rst_i,
  input  logic                                ireq_i,
  input  logic [mem_geom_pkg::ADDR_WIDTH-1:0] iaddr_i,
  output logic                                iack_o,
  output logic [LINE_WIDTH-1:0]               idata_o,
  input  logic                                dreq_i,
  input  logic                                dwe_i,
  input  logic [mem_geom_pkg::ADDR_WIDTH-1:0] daddr_i,
  input  mem_geom_pkg::access_size_t          dsize_i,
  input  logic [LINE_WIDTH-1:0]               dwdata_i,
  output logic                                dack_o,
  output logic [LINE_WIDTH-1:0]               drdata_o
);

  import mem_geom_pkg::*;

  logic                  rd_req_valid;
  logic                  wr_req_valid;
  logic                  req_is_instr;
  logic [ADDR_WIDTH-1:0] mem_addr;
  logic [LINE_WIDTH-1:0] mem_wdata;
  access_size_t          mem_size;
  logic                  data_valid;
  logic                  data_is_instr;
  logic [LINE_WIDTH-1:0] mem_rdata;

  mem_arbiter #(
    .MEM_SIZE   (MEM_SIZE),
    .LINE_WIDTH (LINE_WIDTH)
  ) u_arbiter (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .ireq_i          (ireq_i),
    .iaddr_i         (iaddr_i),
    .iack_o          (iack_o),
    .idata_o         (idata_o),
    .dreq_i          (dreq_i),
    .dwe_i           (dwe_i),
    .daddr_i         (daddr_i),
    .dsize_i         (dsize_i),
    .dwdata_i        (dwdata_i),
    .dack_o          (dack_o),
    .drdata_o        (drdata_o),
    .rd_req_valid_o  (rd_req_valid),
    .wr_req_valid_o  (wr_req_valid),
    .req_is_instr_o  (req_is_instr),
    .address_o       (mem_addr),
    .wr_data_o       (mem_wdata),
    .access_size_o   (mem_size),
    .data_valid_i    (data_valid),
    .data_is_instr_i (data_is_instr),
    .data_i          (mem_rdata)
  );

  mem #(
    .MEM_SIZE   (MEM_SIZE),
    .LINE_WIDTH (LINE_WIDTH)
  ) u_mem (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .rd_req_valid_i  (rd_req_valid),
    .wr_req_valid_i  (wr_req_valid),
    .req_is_instr_i  (req_is_instr),
    .address_i       (mem_addr),
    .wr_data_i       (mem_wdata),
    .access_size_i   (mem_size),
    .data_valid_o    (data_valid),
    .data_is_instr_o (data_is_instr),
    .data_o          (mem_rdata)
  );

endmodule

// File: verif/mem_checker.sv
module mem_checker #(
  parameter int MEM_SIZE   = mem_geom_pkg::MEM_SIZE,
  parameter int LINE_WIDTH = mem_geom_pkg::LINE_WIDTH
)(
  input logic                                clk_i,
  input logic                                rst_i,
  input logic                                ireq_i,
  input logic [mem_geom_pkg::ADDR_WIDTH-1:0] iaddr_i,
  input logic                                iack_i,
  input logic [LINE_WIDTH-1:0]               idata_i,
  input logic                                dreq_i,
  input logic                                dwe_i,
  input logic [mem_geom_pkg::ADDR_WIDTH-1:0] daddr_i,
  input mem_geom_pkg::access_size_t          dsize_i,
  input logic [LINE_WIDTH-1:0]               dwdata_i,
  input logic                                dack_i,
  input logic [LINE_WIDTH-1:0]               drdata_i
);

  timeunit 1ns;
  timeprecision 100ps;

  import mem_geom_pkg::*;
  import mem_req_pkg::*;

  localparam int LINE_BYTES = LINE_WIDTH / 8;

  logic [7:0] model [MEM_SIZE];
  logic       prev_rst, prev_iack, prev_dack, prev_ireq, prev_dreq;
  int         checks, errors, test_checks, test_errors, tests_run, tests_ok;
  int         ireqs, iacks, dreqs, dacks;

  function automatic int size_bytes(access_size_t size);
    case (size)
      SIZE_BYTE: return 1;
      SIZE_HALF: return 2;
      SIZE_WORD: return 4;
      default:   return LINE_BYTES;
    endcase
  endfunction

  task automatic problem(string msg);
    $display("ERROR at %0t: %s", $time, msg);
    errors++;
    test_errors++;
  endtask

  task automatic check_line(client_t who, int addr, logic [LINE_WIDTH-1:0] got);
    logic [LINE_WIDTH-1:0] exp;
    for (int i = 0; i < LINE_BYTES; i++) begin
      exp[8*i +: 8] = model[addr + i];  // Little-endian from the address
    end
    checks++;
    test_checks++;
    if (got !== exp) begin
      $display("FAILED at %0t: %s read at 0x%03h returned %h, expected %h",
               $time, who.name(), addr, got, exp);
      errors++;
      test_errors++;
    end
  endtask

  task automatic apply_write(int addr, access_size_t size, logic [LINE_WIDTH-1:0] data);
    for (int i = 0; i < size_bytes(size); i++) begin
      model[addr + i] = data[8*i +: 8];
    end
  endtask

  task automatic finish_test(string name);
    if (ireqs != iacks || dreqs != dacks) begin
      problem($sformatf("request and ack counts differ (instr %0d/%0d, data %0d/%0d)",
                        ireqs, iacks, dreqs, dacks));
    end
    tests_run++;
    if (test_errors == 0) begin
      tests_ok++;
      $display("test %s: ok, %0d checks", name, test_checks);
    end else begin
      $display("test %s: %0d errors in %0d checks", name, test_errors, test_checks);
    end
    test_checks = 0;
    test_errors = 0;
    ireqs = 0;
    iacks = 0;
    dreqs = 0;
    dacks = 0;
  endtask

  task automatic print_summary();
    $display("summary: %0d tests, %0d ok, %0d with errors; %0d checks, %0d errors",
             tests_run, tests_ok, tests_run - tests_ok, checks, errors);
  endtask

  initial begin
    for (int i = 0; i < MEM_SIZE; i++) begin
      model[i] = 8'h00;
    end
    $readmemh("mem/mem_init.mem", model);
    {prev_rst, prev_iack, prev_dack, prev_ireq, prev_dreq} = '0;
    {checks, errors, test_checks, test_errors, tests_run, tests_ok} = '0;
    {ireqs, iacks, dreqs, dacks} = '0;
    forever begin
      @(posedge clk_i);
      #1;  // Outputs settled after the clock edge
      if (!rst_i || !prev_rst) begin
        checks++;
        test_checks++;
        if (iack_i !== 1'b0 || dack_i !== 1'b0) begin
          problem("ack not low during reset or right after it");
        end
      end else begin
        if (ireq_i && !prev_ireq) ireqs++;
        if (dreq_i && !prev_dreq) dreqs++;
        // Instruction before data since a write acked in the same cycle lands later
        if (iack_i && !prev_iack) begin
          iacks++;
          if (!ireq_i) problem("instruction ack rose with no request");
          check_line(CLIENT_INSTR, iaddr_i, idata_i);
        end
        if (dack_i && !prev_dack) begin
          dacks++;
          if (!dreq_i) problem("data ack rose with no request");
          if (dwe_i) apply_write(daddr_i, dsize_i, dwdata_i);
          else check_line(CLIENT_DATA, daddr_i, drdata_i);
        end
        if (prev_iack && !iack_i && ireq_i) problem("instruction ack fell while req was high");
        if (prev_dack && !dack_i && dreq_i) problem("data ack fell while req was high");
      end
      prev_rst  = rst_i;
      prev_iack = iack_i;
      prev_dack = dack_i;
      prev_ireq = ireq_i;
      prev_dreq = dreq_i;
    end
  end

endmodule

// File: verif/tb_top.sv
module tb_top;

  timeunit 1ns;
  timeprecision 100ps;

  import mem_geom_pkg::*;

  localparam int MEM_BYTES   = 4096;
  localparam int LINE_W      = 128;
  localparam int LINE_BYTES  = LINE_W / 8;
  localparam int HALF        = MEM_BYTES / 2;
  localparam int IMAGE_LINES = 14;
  localparam int TOTAL_REQS  = 32 + 16 + 32 + 300;
  localparam int CYCLE_LIMIT = TOTAL_REQS * 2 * 20 + 200;

  logic                  clk_i, rst_i;
  logic                  ireq, iack, dreq, dwe, dack;
  logic [ADDR_WIDTH-1:0] iaddr, daddr, waddr;
  logic [LINE_W-1:0]     idata, dwdata, drdata;
  access_size_t          dsize;
  logic [ADDR_WIDTH-1:0] written_q [$];

  mem_subsys_top #(.MEM_SIZE(MEM_BYTES), .LINE_WIDTH(LINE_W)) UUT (
    .clk_i(clk_i), .rst_i(rst_i),
    .ireq_i(ireq), .iaddr_i(iaddr), .iack_o(iack), .idata_o(idata),
    .dreq_i(dreq), .dwe_i(dwe), .daddr_i(daddr), .dsize_i(dsize),
    .dwdata_i(dwdata), .dack_o(dack), .drdata_o(drdata)
  );

  mem_checker #(.MEM_SIZE(MEM_BYTES), .LINE_WIDTH(LINE_W)) u_checker (
    .clk_i(clk_i), .rst_i(rst_i),
    .ireq_i(ireq), .iaddr_i(iaddr), .iack_i(iack), .idata_i(idata),
    .dreq_i(dreq), .dwe_i(dwe), .daddr_i(daddr), .dsize_i(dsize),
    .dwdata_i(dwdata), .dack_i(dack), .drdata_i(drdata)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Instruction reads stay in the lower half and data traffic in the upper half
  function automatic logic [ADDR_WIDTH-1:0] fetch_addr();
    return ADDR_WIDTH'($urandom % (HALF - LINE_BYTES + 1));
  endfunction

  function automatic logic [ADDR_WIDTH-1:0] data_addr();
    return ADDR_WIDTH'(HALF + $urandom % (HALF - LINE_BYTES + 1));
  endfunction

  function automatic logic [LINE_W-1:0] rand_line();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  task automatic fetch_line(input logic [ADDR_WIDTH-1:0] addr);
    iaddr = addr;
    ireq  = 1'b1;
    do @(negedge clk_i); while (!iack);
    ireq = 1'b0;
    do @(negedge clk_i); while (iack);
  endtask

  task automatic data_access(input logic we, input logic [ADDR_WIDTH-1:0] addr,
                             input access_size_t size, input logic [LINE_W-1:0] wdata);
    dwe    = we;
    daddr  = addr;
    dsize  = size;
    dwdata = wdata;
    dreq   = 1'b1;
    do @(negedge clk_i); while (!dack);
    dreq = 1'b0;
    do @(negedge clk_i); while (dack);
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("run timed out with tests unfinished after %0d cycles", cycles);
    $display("tests failed");
    $finish;
  end

  initial begin
    void'($urandom(32'hd5555175));
    {ireq, dreq, dwe} = '0;
    {iaddr, daddr, waddr} = '0;
    dwdata = '0;
    dsize  = SIZE_BYTE;
    rst_i  = 1'b0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b1;
    repeat (2) @(negedge clk_i);
    u_checker.finish_test("reset");

    repeat (32) begin
      if ($urandom % 2) fetch_line(ADDR_WIDTH'(($urandom % IMAGE_LINES) * 256));
      else fetch_line(ADDR_WIDTH'(($urandom % (MEM_BYTES / LINE_BYTES)) * LINE_BYTES));
    end
    u_checker.finish_test("image preload");

    for (int s = 0; s < 4; s++) begin
      repeat (2) begin
        waddr = data_addr();
        data_access(1'b1, waddr, access_size_t'(s), rand_line());
        data_access(1'b0, waddr, SIZE_LINE, '0);  // Read back the whole line
      end
    end
    u_checker.finish_test("sized writes");

    fork
      repeat (8) fetch_line(fetch_addr());
      repeat (8) begin
        waddr = data_addr();
        data_access(1'b1, waddr, access_size_t'($urandom % 4), rand_line());
        data_access(1'b0, waddr, SIZE_LINE, '0);  // Overlaps the fetches in flight
        written_q.push_back(waddr);
      end
    join
    foreach (written_q[k]) fetch_line(written_q[k]);
    u_checker.finish_test("concurrent ports");

    fork
      repeat (150) begin
        repeat ($urandom % 4) @(negedge clk_i);
        fetch_line(fetch_addr());
      end
      repeat (150) begin
        repeat ($urandom % 4) @(negedge clk_i);
        data_access(1'($urandom % 2), data_addr(), access_size_t'($urandom % 4), rand_line());
      end
    join
    u_checker.finish_test("random mix");

    u_checker.print_summary();
    if (u_checker.errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: mem/mem_init.mem
// One image line per row: @ sets the byte address, then 16 bytes in hex
// Byte at address 0xKXY holds 0xKY, so each line shows where it came from
@000 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f
@100 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f
@200 20 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d 2e 2f
@300 30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f
@400 40 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f
@500 50 51 52 53 54 55 56 57 58 59 5a 5b 5c 5d 5e 5f
@600 60 61 62 63 64 65 66 67 68 69 6a 6b 6c 6d 6e 6f
@700 70 71 72 73 74 75 76 77 78 79 7a 7b 7c 7d 7e 7f
@800 80 81 82 83 84 85 86 87 88 89 8a 8b 8c 8d 8e 8f
@900 90 91 92 93 94 95 96 97 98 99 9a 9b 9c 9d 9e 9f
@a00 a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 aa ab ac ad ae af
@b00 b0 b1 b2 b3 b4 b5 b6 b7 b8 b9 ba bb bc bd be bf
@c00 c0 c1 c2 c3 c4 c5 c6 c7 c8 c9 ca cb cc cd ce cf
@d00 d0 d1 d2 d3 d4 d5 d6 d7 d8 d9 da db dc dd de df

// File: build.f
common/mem_geom_pkg.sv
common/mem_req_pkg.sv
mem/mem.sv
verilog/mem_arbiter.sv
verilog/mem_subsys_top.sv
verif/mem_checker.sv
verif/tb_top.sv

// File: Makefile
SRCS = $(wildcard common/*.sv mem/*.sv verilog/*.sv verif/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_top: $(SRCS) build.f
	verilator --binary --timing -Wno-fatal --top-module tb_top -f build.f

run: obj_dir/Vtb_top
	@out="$$(./obj_dir/Vtb_top)"; echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
